//--- source/raster_defs.svh
//####################
// rasterizer widths, sizes, queue depths
// and register word addresses
//####################
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

`define RASTER_CORDW      16  // signed coordinate width
`define RASTER_CIDXW      4   // colour index width
`define RASTER_FB_W       64  // frame buffer width in pixels
`define RASTER_FB_H       64  // frame buffer height in pixels
`define RASTER_FB_AW      12  // log2 of width times height
`define RASTER_CMD_DEPTH  4   // line commands waiting
`define RASTER_PIX_DEPTH  8   // pixels between stepper and memory

`define RASTER_REG_X0     0   // start x
`define RASTER_REG_Y0     1   // start y
`define RASTER_REG_X1     2   // end x
`define RASTER_REG_Y1     3   // end y
`define RASTER_REG_CIDX   4   // line colour
`define RASTER_REG_CMD    5   // write pushes a line
`define RASTER_REG_STATUS 6   // bit 0 busy
`define RASTER_FB_SEL     12  // adr bit of the frame buffer window

`endif

//--- source/raster_pkg.sv
//####################
// drawing types: coordinates, colour,
// line commands and pixel records
//####################
`include "raster_defs.svh"

package raster_pkg;

    typedef logic signed [`RASTER_CORDW-1:0] coord_t;  // screen position, may be off screen
    typedef logic [`RASTER_CIDXW-1:0] cidx_t;          // palette index

    // one queued line, endpoints inclusive
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    // one plotted point, not yet clipped
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

endpackage

//--- source/wb_pkg.sv
//####################
// wishbone classic request and response
//####################

package wb_pkg;

    // host to slave
    typedef struct packed {
        logic        cyc;  // bus cycle open
        logic        stb;  // transfer strobe
        logic        we;   // write
        logic [15:0] adr;  // word address
        logic [31:0] dat;  // write data
        logic [3:0]  sel;  // byte lanes
    } wb_req_t;

    // slave to host
    typedef struct packed {
        logic [31:0] dat;  // read data
        logic        ack;  // one cycle per request
    } wb_resp_t;

endpackage

//--- source/sync_fifo.sv
//####################
// sync fifo, fall-through output
//####################
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  depth  = 4
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire item_t in_data,
    input  wire logic  in_valid,
    output logic       in_ready,   // not full
    output item_t      out_data,   // head entry
    output logic       out_valid,  // not empty
    input  wire logic  out_ready,
    output logic       empty
);
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;  // pointer width
    localparam int cw = $clog2(depth + 1);                // count width

    item_t         mem [depth];  // entry storage
    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic [cw-1:0] count;        // entries held
    logic          push;
    logic          pop;

    always_comb begin
        in_ready  = (count != cw'(depth));
        out_valid = (count != '0);
        empty     = (count == '0);
        out_data  = mem[rd_ptr];  // head visible without a pop
        push      = in_valid && in_ready;
        pop       = out_valid && out_ready;
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (push) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
        if (pop) rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
        if (push && !pop) count <= count + 1'b1;
        else if (pop && !push) count <= count - 1'b1;  // both at once keeps count
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
    end

endmodule

//--- source/draw_line.sv
//####################
// bresenham line stepper
//####################
`timescale 1ns/1ps
`include "raster_defs.svh"

module draw_line import raster_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,    // load endpoints
    input  wire logic   oe,       // pixel taken, may step
    input  wire coord_t x0,       // first point
    input  wire coord_t y0,
    input  wire coord_t x1,       // last point
    input  wire coord_t y1,
    output coord_t      x,        // current pixel
    output coord_t      y,
    output logic        drawing,  // x,y valid
    output logic        done      // one cycle after last pixel taken
);
    localparam int ew = `RASTER_CORDW + 3;  // room for twice the error

    typedef enum logic [1:0] {st_idle, st_init, st_draw, st_done} state_t;
    state_t state;

    coord_t               xe;        // end point copy
    coord_t               ye;
    logic signed [ew-1:0] dx;        // abs x distance
    logic signed [ew-1:0] dy;        // minus abs y distance
    logic signed [ew-1:0] err;       // running error
    logic                 right;     // x steps up
    logic                 down;      // y steps up
    logic signed [ew-1:0] dx_in;     // raw deltas at start
    logic signed [ew-1:0] dy_in;
    logic signed [ew-1:0] err_now;   // error used this cycle
    logic signed [ew-1:0] e2;
    logic signed [ew-1:0] err_next;
    logic                 step_x;
    logic                 step_y;
    logic                 last;      // at end point

    always_comb begin
        dx_in    = x1 - x0;  // sign extended to ew
        dy_in    = y1 - y0;
        err_now  = (state == st_init) ? dx + dy : err;  // first step seeds error
        e2       = err_now <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err_now;
        if (step_x) err_next = err_next + dy;
        if (step_y) err_next = err_next + dx;
        last     = (x == xe) && (y == ye);
        drawing  = (state == st_init) || (state == st_draw);
        done     = (state == st_done);
    end

    always_ff @(posedge clk) begin
        case (state)
            st_init, st_draw: begin
                if (oe) begin  // current pixel accepted
                    if (last) begin
                        state <= st_done;
                    end else begin
                        state <= st_draw;
                        err   <= err_next;
                        if (step_x) x <= right ? x + 1 : x - 1;
                        if (step_y) y <= down ? y + 1 : y - 1;
                    end
                end
            end
            st_done: state <= st_idle;
            default: begin  // idle
                if (start) begin
                    x     <= x0;
                    y     <= y0;
                    xe    <= x1;
                    ye    <= y1;
                    dx    <= (dx_in < 0) ? -dx_in : dx_in;
                    dy    <= (dy_in < 0) ? dy_in : -dy_in;
                    right <= (dx_in >= 0);
                    down  <= (dy_in >= 0);
                    state <= st_init;
                end
            end
        endcase
        if (rst) state <= st_idle;
    end

endmodule

//--- source/render_line.sv
//####################
// line command sequencer, owns the stepper
//####################
`timescale 1ns/1ps

module render_line import raster_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire line_cmd_t cmd,        // queued line
    input  wire logic      cmd_valid,
    output logic           cmd_ready,  // only when idle
    output pixel_t         pix,        // coordinate plus colour
    output logic           pix_valid,
    input  wire logic      pix_ready,  // also the stepper enable
    output logic           active      // line in progress
);
    typedef enum logic [1:0] {st_idle, st_start, st_run} state_t;
    state_t state;

    line_cmd_t cur;          // line being drawn
    logic      line_start;   // pulse into stepper
    logic      line_done;
    logic      drawing;
    coord_t    px;
    coord_t    py;

    always_ff @(posedge clk) begin
        case (state)
            st_start: state <= st_run;
            st_run: begin
                if (line_done) state <= st_idle;  // pixels may still sit in the queue
            end
            default: begin  // idle
                if (cmd_valid) begin
                    cur   <= cmd;
                    state <= st_start;
                end
            end
        endcase
        if (rst) state <= st_idle;
    end

    always_comb begin
        cmd_ready  = (state == st_idle);
        line_start = (state == st_start);
        active     = (state != st_idle);
        pix        = '{x: px, y: py, cidx: cur.cidx};
        pix_valid  = drawing;  // stepper holds x,y until taken
    end

    draw_line draw_line_inst (
        .clk,
        .rst,
        .start(line_start),
        .oe(pix_ready),
        .x0(cur.x0),
        .y0(cur.y0),
        .x1(cur.x1),
        .y1(cur.y1),
        .x(px),
        .y(py),
        .drawing,
        .done(line_done)
    );

endmodule

//--- source/frame_buffer.sv
//####################
// 64x64 colour memory, clipped pixel
// writes, bus port with priority
//####################
`timescale 1ns/1ps
`include "raster_defs.svh"

module frame_buffer import raster_pkg::*, wb_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire pixel_t  pix,
    input  wire logic    pix_valid,
    output logic         pix_ready,  // low while bus busy
    input  wire wb_req_t bus_req,
    input  wire logic    bus_sel,    // frame buffer window hit
    output wb_resp_t     bus_resp
);
    localparam int aw    = `RASTER_FB_AW;
    localparam int fb_w  = `RASTER_FB_W;
    localparam int fb_h  = `RASTER_FB_H;
    localparam int depth = fb_w * fb_h;

    cidx_t         mem [depth];  // not cleared at reset
    cidx_t         rd_data;      // registered read
    logic [1:0]    stage;        // 0 idle, 1 read wait, 2 ack
    logic          bus_new;      // first cycle of a request
    logic          bus_active;
    logic          pix_in;       // inside the buffer
    logic          pix_take;
    logic          wr_en;
    logic [aw-1:0] bus_addr;
    logic [aw-1:0] pix_addr;
    logic [aw-1:0] wr_addr;
    cidx_t         wr_data;

    always_comb begin
        bus_new    = bus_sel && (stage == 2'd0);
        bus_active = bus_sel || (stage != 2'd0);
        pix_ready  = !bus_active;  // bus wins
        pix_in     = (pix.x >= 0) && (pix.x < fb_w) && (pix.y >= 0) && (pix.y < fb_h);
        pix_addr   = aw'(pix.y * fb_w + pix.x);  // row major
        bus_addr   = bus_req.adr[aw-1:0];
        pix_take   = pix_valid && pix_ready && pix_in;  // clipped pixels accepted, dropped
        wr_en      = (bus_new && bus_req.we && bus_req.sel[0]) || pix_take;
        wr_addr    = bus_new ? bus_addr : pix_addr;
        wr_data    = bus_new ? bus_req.dat[`RASTER_CIDXW-1:0] : pix.cidx;
        bus_resp   = '{dat: 32'(rd_data), ack: (stage == 2'd2)};
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;  // single write port
        if (bus_new) rd_data <= mem[bus_addr];
    end

    always_ff @(posedge clk) begin
        if (bus_new) stage <= 2'd1;
        else if (stage == 2'd1) stage <= 2'd2;
        else if (stage == 2'd2) stage <= 2'd0;  // host drops request on ack
        if (rst) stage <= 2'd0;
    end

endmodule

//--- source/raster_regs.sv
//####################
// wishbone slave, line registers,
// command push and status
//####################
`timescale 1ns/1ps
`include "raster_defs.svh"

module raster_regs import raster_pkg::*, wb_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire wb_req_t  bus_req,
    output wb_resp_t      bus_resp,
    output logic          fb_sel,     // request targets frame buffer
    input  wire wb_resp_t fb_resp,
    output line_cmd_t     cmd,        // current register set
    output logic          cmd_valid,
    input  wire logic     cmd_ready,
    input  wire logic     busy        // any queue or sequencer work
);
    localparam int fb_bit = `RASTER_FB_SEL;

    coord_t      x0_r;
    coord_t      y0_r;
    coord_t      x1_r;
    coord_t      y1_r;
    cidx_t       cidx_r;
    logic        reg_ack;   // one cycle after request
    logic [31:0] reg_dat;
    logic        req;
    logic        reg_hit;   // register window
    logic        wr_cmd;
    logic        take;      // accept this request

    always_comb begin
        req       = bus_req.cyc && bus_req.stb;
        fb_sel    = req && bus_req.adr[fb_bit];
        reg_hit   = req && !bus_req.adr[fb_bit];
        wr_cmd    = reg_hit && bus_req.we && (bus_req.adr == `RASTER_REG_CMD);
        cmd_valid = wr_cmd && !reg_ack;  // held by host until queue has room
        take      = reg_hit && !reg_ack && (!wr_cmd || cmd_ready);
        cmd       = '{x0: x0_r, y0: y0_r, x1: x1_r, y1: y1_r, cidx: cidx_r};
        bus_resp.ack = reg_ack || fb_resp.ack;
        bus_resp.dat = fb_resp.ack ? fb_resp.dat : reg_dat;
    end

    always_ff @(posedge clk) begin
        reg_ack <= take;
        if (take) begin
            if (bus_req.we && |bus_req.sel) begin
                case (bus_req.adr)
                    `RASTER_REG_X0:   x0_r   <= bus_req.dat[`RASTER_CORDW-1:0];
                    `RASTER_REG_Y0:   y0_r   <= bus_req.dat[`RASTER_CORDW-1:0];
                    `RASTER_REG_X1:   x1_r   <= bus_req.dat[`RASTER_CORDW-1:0];
                    `RASTER_REG_Y1:   y1_r   <= bus_req.dat[`RASTER_CORDW-1:0];
                    `RASTER_REG_CIDX: cidx_r <= bus_req.dat[`RASTER_CIDXW-1:0];
                    default: ;  // cmd push handled by the queue
                endcase
            end
            case (bus_req.adr)
                `RASTER_REG_X0:     reg_dat <= 32'(x0_r);  // sign extended
                `RASTER_REG_Y0:     reg_dat <= 32'(y0_r);
                `RASTER_REG_X1:     reg_dat <= 32'(x1_r);
                `RASTER_REG_Y1:     reg_dat <= 32'(y1_r);
                `RASTER_REG_CIDX:   reg_dat <= 32'(cidx_r);
                `RASTER_REG_STATUS: reg_dat <= {31'd0, busy};
                default:            reg_dat <= '0;
            endcase
        end
        if (rst) begin
            reg_ack <= 1'b0;
            x0_r    <= '0;
            y0_r    <= '0;
            x1_r    <= '0;
            y1_r    <= '0;
            cidx_r  <= '0;
        end
    end

endmodule

//--- source/line_raster_top.sv
//####################
// line rasterizer top
//####################
`timescale 1ns/1ps
`include "raster_defs.svh"

module line_raster_top import raster_pkg::*, wb_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire wb_req_t wb_req,   // host side
    output wb_resp_t     wb_resp
);
    line_cmd_t cmd_in;         // regs to command queue
    line_cmd_t cmd_out;        // command queue to sequencer
    logic      cmd_in_valid;
    logic      cmd_in_ready;
    logic      cmd_out_valid;
    logic      cmd_out_ready;
    logic      cmd_empty;
    pixel_t    pix_in;         // sequencer to pixel queue
    pixel_t    pix_out;        // pixel queue to memory
    logic      pix_in_valid;
    logic      pix_in_ready;
    logic      pix_out_valid;
    logic      pix_out_ready;
    logic      pix_empty;
    logic      fb_sel;
    wb_resp_t  fb_resp;
    logic      render_active;
    logic      busy;

    assign busy = !cmd_empty || !pix_empty || render_active;

    raster_regs raster_regs_inst (
        .clk, .rst,
        .bus_req(wb_req), .bus_resp(wb_resp),
        .fb_sel, .fb_resp,
        .cmd(cmd_in), .cmd_valid(cmd_in_valid), .cmd_ready(cmd_in_ready),
        .busy
    );

    sync_fifo #(.item_t(line_cmd_t), .depth(`RASTER_CMD_DEPTH)) cmd_fifo_inst (
        .clk, .rst,
        .in_data(cmd_in), .in_valid(cmd_in_valid), .in_ready(cmd_in_ready),
        .out_data(cmd_out), .out_valid(cmd_out_valid), .out_ready(cmd_out_ready),
        .empty(cmd_empty)
    );

    render_line render_line_inst (
        .clk, .rst,
        .cmd(cmd_out), .cmd_valid(cmd_out_valid), .cmd_ready(cmd_out_ready),
        .pix(pix_in), .pix_valid(pix_in_valid), .pix_ready(pix_in_ready),
        .active(render_active)
    );

    sync_fifo #(.item_t(pixel_t), .depth(`RASTER_PIX_DEPTH)) pix_fifo_inst (
        .clk, .rst,
        .in_data(pix_in), .in_valid(pix_in_valid), .in_ready(pix_in_ready),
        .out_data(pix_out), .out_valid(pix_out_valid), .out_ready(pix_out_ready),
        .empty(pix_empty)
    );

    frame_buffer frame_buffer_inst (
        .clk, .rst,
        .pix(pix_out), .pix_valid(pix_out_valid), .pix_ready(pix_out_ready),
        .bus_req(wb_req), .bus_sel(fb_sel), .bus_resp(fb_resp)
    );

endmodule

//--- tests/tb_clock.sv
//####################
// testbench clock and reset
//####################
`timescale 1ns/1ps

module tb_clock #(
    parameter real period     = 4.0,  // ns
    parameter int  rst_cycles = 10
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;  // released on an edge
    end

endmodule

//--- tests/line_raster_tb.sv
//####################
// line rasterizer testbench: bus tasks,
// reference rasterizer, read checker
//####################
`timescale 1ns/1ps
`include "raster_defs.svh"

module line_raster_tb import raster_pkg::*, wb_pkg::*; ();
    localparam int fb_w = `RASTER_FB_W;
    localparam int fb_h = `RASTER_FB_H;
    localparam int fb_size = fb_w * fb_h;
    localparam logic [15:0] fb_base = 16'(1 << `RASTER_FB_SEL);  // frame buffer window
    localparam logic [15:0] reg_status = 16'(`RASTER_REG_STATUS);
    localparam int ack_timeout = 2000;  // cycles, covers a full command queue
    localparam int idle_limit = 5000;   // status polls

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_resp_t    wb_resp;
    cidx_t       shadow [fb_size];  // expected image
    string       exp_name_q [$];    // pending read checks
    logic [31:0] exp_val_q [$];

    tb_clock #(.period(4.0), .rst_cycles(10)) clock_gen (.clk, .rst);

    line_raster_top dut (.clk, .rst, .wb_req, .wb_resp);

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    // compares each read ack against the next queued expectation
    always @(negedge clk) begin
        if (wb_resp.ack && !wb_req.we && exp_val_q.size() > 0)
            check_value(exp_name_q.pop_front(), exp_val_q.pop_front(), wb_resp.dat);
    end

    // one classic cycle, request held until ack
    task automatic bus_access(logic we, logic [15:0] adr, logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
        @(negedge clk);
        while (!wb_resp.ack) begin
            if (waited >= ack_timeout)
                abort_run($sformatf("no bus ack for address %h within %0d cycles",
                                    adr, ack_timeout));
            else begin
                waited++;
                @(negedge clk);
            end
        end
        rdat = wb_resp.dat;
        @(posedge clk);
        wb_req <= '0;  // drop after ack
    endtask

    task automatic bus_write(logic [15:0] adr, logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(logic [15:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, rdat);
    endtask

    // expected read, checked by the monitor when the ack arrives
    task automatic read_expect(string name, logic [15:0] adr, logic [31:0] value);
        logic [31:0] rdat;
        exp_name_q.push_back(name);
        exp_val_q.push_back(value);
        bus_read(adr, rdat);
    endtask

    // bresenham with clipping, applied to the shadow image
    function automatic void reference_line(int x0, int y0, int x1, int y1, int c);
        int dx;
        int dy;
        int err;
        int e2;
        int sx;
        int sy;
        int x;
        int y;
        int steps;
        bit finished;
        dx = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy = (y1 > y0) ? y0 - y1 : y1 - y0;  // negated distance
        sx = (x1 >= x0) ? 1 : -1;
        sy = (y1 >= y0) ? 1 : -1;
        err = dx + dy;
        x = x0;
        y = y0;
        steps = 0;
        finished = 1'b0;
        while (!finished && steps < 1024) begin
            if (x >= 0 && x < fb_w && y >= 0 && y < fb_h)
                shadow[y * fb_w + x] = cidx_t'(c);  // outside points dropped
            if (x == x1 && y == y1) begin
                finished = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y += sy;
                end
            end
            steps++;
        end
    endfunction

    task automatic queue_line(int x0, int y0, int x1, int y1, int c);
        bus_write(16'(`RASTER_REG_X0), 32'(x0));
        bus_write(16'(`RASTER_REG_Y0), 32'(y0));
        bus_write(16'(`RASTER_REG_X1), 32'(x1));
        bus_write(16'(`RASTER_REG_Y1), 32'(y1));
        bus_write(16'(`RASTER_REG_CIDX), 32'(c));
        bus_write(16'(`RASTER_REG_CMD), 32'd0);  // stalls while queue full
        reference_line(x0, y0, x1, y1, c);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int polls;
        polls = 0;
        bus_read(reg_status, status);
        while (status[0]) begin
            if (polls >= idle_limit) abort_run("busy never cleared after drawing");
            else begin
                polls++;
                bus_read(reg_status, status);
            end
        end
    endtask

    task automatic clear_frame();
        for (int a = 0; a < fb_size; a++) begin
            bus_write(fb_base | 16'(a), 32'd0);
            shadow[a] = '0;
        end
    endtask

    task automatic compare_frame();
        for (int a = 0; a < fb_size; a++)
            read_expect($sformatf("fb[%0d,%0d]", a % fb_w, a / fb_w), fb_base | 16'(a),
                        32'(shadow[a]));
    endtask

    initial begin
        int waited;
        int polls;
        int rx0;
        int ry0;
        int rx1;
        int ry1;
        int rc;
        logic [31:0] rdat;
        logic [31:0] status;
        wb_req = '0;
        rdat = $urandom(79);  // seed once
        waited = 0;
        @(negedge clk);
        while (rst !== 1'b0) begin
            if (waited >= 100) abort_run("reset never released");
            else begin
                waited++;
                @(negedge clk);
            end
        end

        check_value("wb_resp.ack", 32'd0, 32'(wb_resp.ack));  // idle bus after reset
        read_expect("status", reg_status, 32'd0);

        bus_write(16'(`RASTER_REG_X0), 32'(-5));
        bus_write(16'(`RASTER_REG_Y0), 32'd17);
        bus_write(16'(`RASTER_REG_X1), 32'd300);
        bus_write(16'(`RASTER_REG_Y1), 32'(-1000));
        bus_write(16'(`RASTER_REG_CIDX), 32'h9);
        read_expect("x0", 16'(`RASTER_REG_X0), 32'(-5));  // sign extended
        read_expect("y0", 16'(`RASTER_REG_Y0), 32'd17);
        read_expect("x1", 16'(`RASTER_REG_X1), 32'd300);
        read_expect("y1", 16'(`RASTER_REG_Y1), 32'(-1000));
        read_expect("cidx", 16'(`RASTER_REG_CIDX), 32'h9);

        clear_frame();
        queue_line(5, 3, 58, 3, 1);     // horizontal
        queue_line(60, 5, 60, 58, 2);   // vertical
        queue_line(10, 60, 10, 60, 3);  // single point
        queue_line(32, 32, 50, 40, 4);  // one per octant
        queue_line(32, 32, 40, 50, 5);
        queue_line(32, 32, 24, 50, 6);
        queue_line(32, 32, 14, 40, 7);
        queue_line(32, 32, 14, 24, 8);
        queue_line(32, 32, 24, 14, 9);
        queue_line(32, 32, 40, 14, 10);
        queue_line(32, 32, 50, 24, 11);
        wait_idle();
        compare_frame();

        for (int n = 0; n < 20; n++) begin  // back to back, overruns the queue
            rx0 = $urandom_range(63, 0);
            ry0 = $urandom_range(63, 0);
            rx1 = $urandom_range(63, 0);
            ry1 = $urandom_range(63, 0);
            rc = $urandom_range(15, 1);
            queue_line(rx0, ry0, rx1, ry1, rc);
        end
        wait_idle();
        compare_frame();

        queue_line(-10, -5, 70, 40, 12);  // partly clipped
        queue_line(-20, 30, 80, 30, 13);
        queue_line(30, -15, 35, 90, 14);
        queue_line(100, 100, -30, -40, 15);
        queue_line(70, 70, 90, 80, 1);    // fully outside
        wait_idle();
        compare_frame();

        queue_line(0, 63, 63, 0, 12);
        queue_line(0, 5, 63, 58, 3);
        polls = 0;
        status = 32'd1;
        while (status[0]) begin  // reads compete with rendering
            if (polls >= idle_limit) abort_run("busy never cleared during frame buffer reads");
            else begin
                for (int k = 0; k < 4; k++)
                    bus_read(fb_base | 16'($urandom_range(fb_size - 1, 0)), rdat);
                bus_read(reg_status, status);
                polls++;
            end
        end
        compare_frame();

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/raster_pkg.sv
source/wb_pkg.sv
source/sync_fifo.sv
source/draw_line.sv
source/render_line.sv
source/frame_buffer.sv
source/raster_regs.sv
source/line_raster_top.sv
tests/tb_clock.sv
tests/line_raster_tb.sv

//--- Bender.yml
package:
  name: line_raster

sources:
  - include_dirs:
      - source
    files:
      - source/raster_pkg.sv
      - source/wb_pkg.sv
      - source/sync_fifo.sv
      - source/draw_line.sv
      - source/render_line.sv
      - source/frame_buffer.sv
      - source/raster_regs.sv
      - source/line_raster_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_clock.sv
      - tests/line_raster_tb.sv
